// ==== files.f ====
src/procPkg.sv
src/control.sv
src/fetch.sv
src/decode.sv
src/execute.sv
src/dataMemory.sv
src/proc.sv
verification/proc_properties.sv
verification/procTb.sv

// ==== src/control.sv ====
//######################################
// Control unit of the 16-bit core
// Run handshake FSM, program-load gating
// and opcode decode into control lines
//######################################
`timescale 1ns/1ps

module control (
   input  logic            clk,
   input  logic            rst,
   input  logic            req,
   output logic            ack,
   output logic            err,
   input  logic            progWrite,
   output logic            imemWrEn,
   input  procPkg::instr_u instr,
   output logic            running,
   output logic            regWrite,
   output logic            aluSrc,
   output logic            immSigned,
   output logic            memWrite,
   output logic            memToReg,
   output logic            branchZero,
   output logic            branchNonZero,
   output procPkg::aluOp_t aluOp,
   output logic            pcClear
);
   import procPkg::*;

   runState_t state;
   logic      errFlag;
   logic      halt;
   logic      illegal;

   assign running  = (state == RUN);
   // PC restarts at 0 on the edge that enters RUN
   assign pcClear  = (state == IDLE) && req;
   // Program loads only while idle
   assign imemWrEn = (state == IDLE) && progWrite;
   assign ack      = (state == DONE);
   // Only ever set while in DONE
   assign err      = errFlag;

   // Opcode decode, every line quiet unless running
   always_comb
   begin
      regWrite      = 1'b0;
      aluSrc        = 1'b0;
      immSigned     = 1'b0;
      memWrite      = 1'b0;
      memToReg      = 1'b0;
      branchZero    = 1'b0;
      branchNonZero = 1'b0;
      aluOp         = ADD;
      halt          = 1'b0;
      illegal       = 1'b0;
      if (running)
      begin
         case (instr.r.opcode)
            HALT:  halt = 1'b1;
            // Retires with no side effect
            NOP:   ;
            RTYPE:
            begin
               regWrite = 1'b1;
               aluOp    = instr.r.func;
            end
            ADDI, SUBI:
            begin
               regWrite  = 1'b1;
               aluSrc    = 1'b1;
               immSigned = 1'b1;
               aluOp     = (instr.r.opcode == ADDI) ? ADD : SUB;
            end
            XORI, ANDNI:
            begin
               regWrite = 1'b1;
               aluSrc   = 1'b1;
               aluOp    = (instr.r.opcode == XORI) ? XOR : ANDN;
            end
            // Address is rs plus signed offset
            LD:
            begin
               regWrite  = 1'b1;
               aluSrc    = 1'b1;
               immSigned = 1'b1;
               memToReg  = 1'b1;
            end
            ST:
            begin
               aluSrc    = 1'b1;
               immSigned = 1'b1;
               memWrite  = 1'b1;
            end
            BEQZ:    branchZero    = 1'b1;
            BNEZ:    branchNonZero = 1'b1;
            default: illegal       = 1'b1;
         endcase
      end
   end

   // Run-state FSM
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         state   <= IDLE;
         errFlag <= 1'b0;
      end
      else
      begin
         case (state)
            IDLE:
            begin
               if (req)
                  state <= RUN;
            end
            RUN:
            begin
               // Stop after HALT or a bad opcode retires
               if (halt || illegal)
               begin
                  state   <= DONE;
                  errFlag <= illegal;
               end
            end
            DONE:
            begin
               if (!req)
               begin
                  state   <= IDLE;
                  errFlag <= 1'b0;
               end
            end
            default: state <= IDLE;
         endcase
      end
   end

endmodule

// ==== src/dataMemory.sv ====
//######################################
// Data memory and write-back select
// Sync write, async read
//######################################
`timescale 1ns/1ps

module dataMemory #(
   parameter int dmemWords = 32
) (
   input  logic                          clk,
   input  logic                          rst,
   input  logic [procPkg::dataWidth-1:0] aluOut,
   input  logic [procPkg::dataWidth-1:0] storeData,
   input  logic                          memWrite,
   input  logic                          memToReg,
   output logic [procPkg::dataWidth-1:0] writeData
);
   import procPkg::*;

   localparam int dmemAddrBits = $clog2(dmemWords);

   logic [dataWidth-1:0]    dmem [dmemWords];
   logic [dmemAddrBits-1:0] addr;
   logic [dataWidth-1:0]    loadData;

   // Address wraps modulo the depth
   assign addr = aluOut[dmemAddrBits-1:0];

   // Cleared on reset, survives between runs
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         for (int k = 0; k < dmemWords; k++)
            dmem[k] <= '0;
      end
      else if (memWrite)
      begin
         dmem[addr] <= storeData;
      end
   end

   assign loadData = dmem[addr];

   // LD writes back memory, everything else the ALU
   assign writeData = memToReg ? loadData : aluOut;

endmodule

// ==== src/decode.sv ====
//######################################
// Decode stage
// Eight-entry register file, operand
// select and immediate extension
//######################################
`timescale 1ns/1ps

module decode (
   input  logic                          clk,
   input  logic                          rst,
   input  procPkg::instr_u               instr,
   input  logic                          regWrite,
   input  logic                          immSigned,
   input  logic [procPkg::dataWidth-1:0] writeData,
   output logic [procPkg::dataWidth-1:0] readData1,
   output logic [procPkg::dataWidth-1:0] readData2,
   output logic [procPkg::dataWidth-1:0] immExt,
   output logic [2:0]                    writeAddr
);
   import procPkg::*;

   logic [dataWidth-1:0] regs [8];
   logic                 isRtype;

   assign isRtype = (instr.r.opcode == RTYPE);

   // rd sits in different bits per view
   assign writeAddr = isRtype ? instr.r.rd : instr.i.rd;

   // Register file, cleared on reset and kept across runs
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         for (int k = 0; k < 8; k++)
            regs[k] <= '0;
      end
      else if (regWrite)
      begin
         regs[writeAddr] <= writeData;
      end
   end

   // Port 1 is always rs
   assign readData1 = regs[instr.r.rs];
   // Port 2 is rt, same bits as the I-format rd (ST data)
   assign readData2 = regs[instr.r.rt];

   // imm is 5 bits, widen to a full word
   always_comb
   begin
      if (immSigned)
         immExt = {{(dataWidth - 5){instr.i.imm[4]}}, instr.i.imm};
      else
         immExt = {{(dataWidth - 5){1'b0}}, instr.i.imm};
   end

endmodule

// ==== src/execute.sv ====
//######################################
// Execute stage
// ALU on register or immediate operand,
// branch condition and next-PC select
//######################################
`timescale 1ns/1ps

module execute (
   input  procPkg::instr_u               instr,
   input  logic [procPkg::dataWidth-1:0] pc,
   input  logic [procPkg::dataWidth-1:0] readData1,
   input  logic [procPkg::dataWidth-1:0] readData2,
   input  logic [procPkg::dataWidth-1:0] immExt,
   input  logic                          aluSrc,
   input  procPkg::aluOp_t               aluOp,
   input  logic                          branchZero,
   input  logic                          branchNonZero,
   output logic [procPkg::dataWidth-1:0] aluOut,
   output logic [procPkg::dataWidth-1:0] nextPc
);
   import procPkg::*;

   logic [dataWidth-1:0] operandB;
   logic [dataWidth-1:0] pcInc;
   logic [dataWidth-1:0] branchOffset;
   logic [dataWidth-1:0] branchTarget;
   logic                 rsZero;
   logic                 taken;

   // Second operand: register or extended imm
   assign operandB = aluSrc ? immExt : readData2;

   // LD/ST address also comes out of the ADD path
   always_comb
   begin
      case (aluOp)
         ADD:     aluOut = readData1 + operandB;
         SUB:     aluOut = readData1 - operandB;
         XOR:     aluOut = readData1 ^ operandB;
         ANDN:    aluOut = readData1 & ~operandB;
         default: aluOut = '0;
      endcase
   end

   assign pcInc = pc + 1'b1;

   // Branch offset always signed, independent of immSigned
   assign branchOffset = {{(dataWidth - 5){instr.i.imm[4]}}, instr.i.imm};
   assign branchTarget = pcInc + branchOffset;

   // Condition tests rs only
   assign rsZero = (readData1 == '0);
   assign taken  = (branchZero && rsZero) || (branchNonZero && !rsZero);

   assign nextPc = taken ? branchTarget : pcInc;

endmodule

// ==== src/fetch.sv ====
//######################################
// Fetch stage
// PC register and instruction memory
// with its program-load write port
//######################################
`timescale 1ns/1ps

module fetch #(
   parameter int imemWords = 64
) (
   input  logic                         clk,
   input  logic                         rst,
   input  logic                         imemWrEn,
   input  logic [$clog2(imemWords)-1:0] progAddr,
   input  logic [procPkg::dataWidth-1:0] progData,
   input  logic                         pcClear,
   input  logic                         running,
   input  logic [procPkg::dataWidth-1:0] nextPc,
   output logic [procPkg::dataWidth-1:0] pc,
   output procPkg::instr_u              instr
);
   import procPkg::*;

   localparam int imemAddrBits = $clog2(imemWords);

   logic [dataWidth-1:0] imem [imemWords];

   // Program load port
   always_ff @(posedge clk)
   begin
      if (imemWrEn)
         imem[progAddr] <= progData;
   end

   // PC advances once per running cycle
   always_ff @(posedge clk)
   begin
      if (rst)
         pc <= '0;
      else if (pcClear)
         pc <= '0;
      else if (running)
         pc <= nextPc;
   end

   // Async read, address wraps at the depth
   assign instr = imem[pc[imemAddrBits-1:0]];

endmodule

// ==== src/proc.sv ====
//######################################
// Single-cycle 16-bit core, top level
// Control plus fetch, decode, execute
// and data memory, with retire trace
//######################################
`timescale 1ns/1ps

module proc #(
   parameter int imemWords = 64,
   parameter int dmemWords = 32
) (
   input  logic                          clk,
   input  logic                          rst,
   input  logic                          req,
   input  logic                          progWrite,
   input  logic [$clog2(imemWords)-1:0]  progAddr,
   input  logic [procPkg::dataWidth-1:0] progData,
   output logic                          ack,
   output logic                          err,
   output logic                          retireValid,
   output logic [procPkg::dataWidth-1:0] retirePc,
   output logic                          retireWrEn,
   output logic [2:0]                    retireWrAddr,
   output logic [procPkg::dataWidth-1:0] retireWrData
);
   import procPkg::*;

   // Fetch outputs
   instr_u               instr;
   logic [dataWidth-1:0] pc;

   // Control lines
   logic   imemWrEn;
   logic   running;
   logic   regWrite;
   logic   aluSrc;
   logic   immSigned;
   logic   memWrite;
   logic   memToReg;
   logic   branchZero;
   logic   branchNonZero;
   logic   pcClear;
   aluOp_t aluOp;

   // Datapath
   logic [dataWidth-1:0] readData1;
   logic [dataWidth-1:0] readData2;
   logic [dataWidth-1:0] immExt;
   logic [2:0]           writeAddr;
   logic [dataWidth-1:0] aluOut;
   logic [dataWidth-1:0] nextPc;
   logic [dataWidth-1:0] writeData;

   control i_control (
      .clk(clk), .rst(rst), .req(req), .ack(ack), .err(err),
      .progWrite(progWrite), .imemWrEn(imemWrEn), .instr(instr),
      .running(running), .regWrite(regWrite), .aluSrc(aluSrc),
      .immSigned(immSigned), .memWrite(memWrite), .memToReg(memToReg),
      .branchZero(branchZero), .branchNonZero(branchNonZero),
      .aluOp(aluOp), .pcClear(pcClear)
   );

   fetch #(.imemWords(imemWords)) i_fetch (
      .clk(clk), .rst(rst), .imemWrEn(imemWrEn), .progAddr(progAddr),
      .progData(progData), .pcClear(pcClear), .running(running),
      .nextPc(nextPc), .pc(pc), .instr(instr)
   );

   decode i_decode (
      .clk(clk), .rst(rst), .instr(instr), .regWrite(regWrite),
      .immSigned(immSigned), .writeData(writeData),
      .readData1(readData1), .readData2(readData2),
      .immExt(immExt), .writeAddr(writeAddr)
   );

   execute i_execute (
      .instr(instr), .pc(pc), .readData1(readData1), .readData2(readData2),
      .immExt(immExt), .aluSrc(aluSrc), .aluOp(aluOp),
      .branchZero(branchZero), .branchNonZero(branchNonZero),
      .aluOut(aluOut), .nextPc(nextPc)
   );

   // ST data comes from read port 2
   dataMemory #(.dmemWords(dmemWords)) i_dataMemory (
      .clk(clk), .rst(rst), .aluOut(aluOut), .storeData(readData2),
      .memWrite(memWrite), .memToReg(memToReg), .writeData(writeData)
   );

   // Retire trace, one entry per running cycle
   assign retireValid  = running;
   assign retireWrEn   = regWrite && running;
   assign retirePc     = pc;
   assign retireWrAddr = writeAddr;
   assign retireWrData = writeData;

endmodule

// ==== src/procPkg.sv ====
//######################################
// Shared definitions for the 16-bit core
// Opcodes, function codes, instruction
// word views and the run-state type
//######################################
package procPkg;

   // Machine word size
   localparam int dataWidth = 16;

   // Major opcodes, anything not listed is illegal
   typedef enum logic [4:0] {
      HALT  = 5'd0,
      NOP   = 5'd1,
      RTYPE = 5'd2,
      ADDI  = 5'd3,
      SUBI  = 5'd4,
      XORI  = 5'd5,
      ANDNI = 5'd6,
      LD    = 5'd7,
      ST    = 5'd8,
      BEQZ  = 5'd9,
      BNEZ  = 5'd10
   } opcode_t;

   // R-format function field, ANDN is rs & ~rt
   typedef enum logic [1:0] {
      ADD  = 2'd0,
      SUB  = 2'd1,
      XOR  = 2'd2,
      ANDN = 2'd3
   } func_t;

   // ALU select shares the function encoding
   typedef func_t aluOp_t;

   // Register-register view
   typedef struct packed {
      opcode_t    opcode;
      logic [2:0] rs;
      logic [2:0] rt;
      logic [2:0] rd;
      func_t      func;
   } instrR_t;

   // Immediate view, rd is the data register for ST
   typedef struct packed {
      opcode_t    opcode;
      logic [2:0] rs;
      logic [2:0] rd;
      logic [4:0] imm;
   } instrI_t;

   // Same 16 bits, decoded both ways
   typedef union packed {
      instrR_t r;
      instrI_t i;
   } instr_u;

   typedef enum logic [1:0] {
      IDLE = 2'd0,
      RUN  = 2'd1,
      DONE = 2'd2
   } runState_t;

endpackage

// ==== verification/procTb.sv ====
//######################################
// Testbench for the 16-bit core
// Random programs, ISA model, run
// handshake and retire-trace checks
//######################################
`timescale 1ns/1ps

module procTb;
   import procPkg::*;

   localparam int imemWords    = 64;
   localparam int dmemWords    = 32;
   localparam int imemAddrBits = $clog2(imemWords);
   localparam int progLen      = 24;
   localparam int runs         = 2;
   localparam int resetCycles  = 5;
   // Load plus run per program, with handshake slack
   localparam int cycleLimit   = runs * (2 * progLen + 20) + resetCycles;

   logic                    clk;
   logic                    rst;
   logic                    req;
   logic                    progWrite;
   logic [imemAddrBits-1:0] progAddr;
   logic [dataWidth-1:0]    progData;
   logic                    ack;
   logic                    err;
   logic                    retireValid;
   logic [dataWidth-1:0]    retirePc;
   logic                    retireWrEn;
   logic [2:0]              retireWrAddr;
   logic [dataWidth-1:0]    retireWrData;

   integer               seed;
   int                   errors;
   int                   cycleCount;
   logic [dataWidth-1:0] prog [progLen];
   // Architectural state of the model
   logic [dataWidth-1:0] modelRegs [8];
   logic [dataWidth-1:0] modelMem [dmemWords];

   proc #(.imemWords(imemWords), .dmemWords(dmemWords)) i_dut (
      .clk(clk), .rst(rst), .req(req), .progWrite(progWrite),
      .progAddr(progAddr), .progData(progData), .ack(ack), .err(err),
      .retireValid(retireValid), .retirePc(retirePc), .retireWrEn(retireWrEn),
      .retireWrAddr(retireWrAddr), .retireWrData(retireWrData)
   );

   bind proc procProperties i_props (
      .clk(clk), .rst(rst), .req(req), .ack(ack), .err(err),
      .retireValid(retireValid)
   );

   initial
   begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // Hang guard
   initial
   begin
      cycleCount = 0;
      forever
      begin
         @(posedge clk);
         cycleCount++;
         if (cycleCount > cycleLimit)
         begin
            $display("Timeout: core did not finish within %0d cycles", cycleLimit);
            $display("test failed");
            $finish;
         end
      end
   end

   task automatic checkValue(input string name, input logic [15:0] expected,
                             input logic [15:0] actual);
      if (actual !== expected)
      begin
         errors++;
         $display("Mismatch at %0t: %s expected %h, got %h", $time, name, expected, actual);
      end
   endtask

   // Random legal program, branches forward only
   task automatic buildProgram(input bit endIllegal);
      int          p;
      int          kind;
      int          maxOff;
      int          offset;
      logic [31:0] rnd;
      p = 0;
      while (p < progLen - 1)
      begin
         rnd  = $random(seed);
         kind = int'(rnd[31:28]) % 10;
         case (kind)
            0, 1:       prog[p] = {RTYPE, rnd[10:0]};
            2, 3, 4, 5: prog[p] = {5'(int'(ADDI) + int'(rnd[27:26])), rnd[10:0]};
            6:
            begin
               // ST then LD with the same rs and imm
               if (p < progLen - 2)
               begin
                  prog[p]     = {ST, rnd[10:0]};
                  prog[p + 1] = {LD, rnd[10:8], rnd[25:23], rnd[4:0]};
                  p++;
               end
               else
                  prog[p] = {NOP, rnd[10:0]};
            end
            7: prog[p] = {LD, rnd[10:0]};
            8:
            begin
               // Target must stay at or before the last word
               maxOff = progLen - 2 - p;
               if (maxOff > 15)
                  maxOff = 15;
               offset  = int'(rnd[27:24]) % (maxOff + 1);
               prog[p] = {rnd[20] ? BNEZ : BEQZ, rnd[10:5], offset[4:0]};
            end
            default: prog[p] = {NOP, rnd[10:0]};
         endcase
         p++;
      end
      rnd = $random(seed);
      // Opcodes 11 to 31 are undefined
      if (endIllegal)
         prog[progLen - 1] = {5'(11 + int'(rnd[31:27]) % 21), rnd[10:0]};
      else
         prog[progLen - 1] = {HALT, rnd[10:0]};
   endtask

   task automatic loadProgram();
      for (int k = 0; k < progLen; k++)
      begin
         @(posedge clk);
         progWrite <= 1'b1;
         progAddr  <= imemAddrBits'(k);
         progData  <= prog[k];
      end
      @(posedge clk);
      progWrite <= 1'b0;
   endtask

   // ISA model, one instruction
   task automatic modelStep(input logic [15:0] w, input int pcIn, output int pcOut,
                            output bit wrEn, output logic [2:0] wa,
                            output logic [15:0] wd, output bit stop);
      logic [15:0] a;
      logic [15:0] b;
      logic [15:0] immS;
      logic [15:0] immZ;
      logic [15:0] addr;
      a     = modelRegs[w[10:8]];
      b     = modelRegs[w[7:5]];
      immS  = {{11{w[4]}}, w[4:0]};
      immZ  = {11'b0, w[4:0]};
      addr  = a + immS;
      pcOut = pcIn + 1;
      wrEn  = 1'b0;
      wa    = w[7:5];
      wd    = '0;
      stop  = 1'b0;
      case (w[15:11])
         HALT:  stop = 1'b1;
         NOP:   ;
         RTYPE:
         begin
            wrEn = 1'b1;
            wa   = w[4:2];
            case (w[1:0])
               ADD:     wd = a + b;
               SUB:     wd = a - b;
               XOR:     wd = a ^ b;
               default: wd = a & ~b;
            endcase
         end
         ADDI:
         begin
            wrEn = 1'b1;
            wd   = a + immS;
         end
         SUBI:
         begin
            wrEn = 1'b1;
            wd   = a - immS;
         end
         XORI:
         begin
            wrEn = 1'b1;
            wd   = a ^ immZ;
         end
         ANDNI:
         begin
            wrEn = 1'b1;
            wd   = a & ~immZ;
         end
         LD:
         begin
            wrEn = 1'b1;
            wd   = modelMem[addr % dmemWords];
         end
         ST:    modelMem[addr % dmemWords] = b;
         BEQZ:
         begin
            if (a == 0)
               pcOut = pcIn + 1 + int'($signed(w[4:0]));
         end
         BNEZ:
         begin
            if (a != 0)
               pcOut = pcIn + 1 + int'($signed(w[4:0]));
         end
         default: stop = 1'b1;
      endcase
      if (wrEn)
         modelRegs[wa] = wd;
   endtask

   // Full handshake around one program
   task automatic runProgram(input bit expectIllegal);
      int          pcM;
      int          pcNext;
      bit          stop;
      bit          wrEn;
      logic [2:0]  wa;
      logic [15:0] wd;
      logic [31:0] rnd;
      pcM  = 0;
      stop = 1'b0;
      @(posedge clk);
      req <= 1'b1;
      // Req not yet seen, still idle
      @(negedge clk);
      checkValue("retireValid", 1'b0, retireValid);
      while (!stop)
      begin
         @(posedge clk);
         // Loads during RUN must be dropped
         rnd = $random(seed);
         progWrite <= rnd[31];
         progAddr  <= rnd[imemAddrBits-1:0];
         progData  <= rnd[30:15];
         @(negedge clk);
         modelStep(prog[pcM % progLen], pcM, pcNext, wrEn, wa, wd, stop);
         checkValue("retireValid", 1'b1, retireValid);
         checkValue("ack", 1'b0, ack);
         checkValue("retirePc", 16'(pcM), retirePc);
         checkValue("retireWrEn", wrEn, retireWrEn);
         if (wrEn)
         begin
            checkValue("retireWrAddr", wa, retireWrAddr);
            checkValue("retireWrData", wd, retireWrData);
         end
         pcM = pcNext;
      end
      @(posedge clk);
      progWrite <= 1'b0;
      @(negedge clk);
      checkValue("ack", 1'b1, ack);
      checkValue("err", expectIllegal, err);
      checkValue("retireValid", 1'b0, retireValid);
      @(posedge clk);
      req <= 1'b0;
      // One cycle of DONE left after req drops
      @(negedge clk);
      checkValue("ack", 1'b1, ack);
      @(negedge clk);
      checkValue("ack", 1'b0, ack);
      checkValue("err", 1'b0, err);
      checkValue("retireValid", 1'b0, retireValid);
   endtask

   initial
   begin
      rst       = 1'b1;
      req       = 1'b0;
      progWrite = 1'b0;
      progAddr  = '0;
      progData  = '0;
      seed      = 32'h500ec11c;
      errors    = 0;
      for (int k = 0; k < 8; k++)
         modelRegs[k] = '0;
      for (int k = 0; k < dmemWords; k++)
         modelMem[k] = '0;
      repeat (resetCycles) @(posedge clk);
      rst <= 1'b0;
      @(negedge clk);
      checkValue("ack", 1'b0, ack);
      checkValue("err", 1'b0, err);
      checkValue("retireValid", 1'b0, retireValid);
      checkValue("retireWrEn", 1'b0, retireWrEn);
      // Run 1 stops on HALT
      buildProgram(1'b0);
      loadProgram();
      runProgram(1'b0);
      // Run 2 stops on a bad opcode, regs and memory carry over
      buildProgram(1'b1);
      loadProgram();
      runProgram(1'b1);
      $display("Errors: %0d, assertion failures: %0d", errors, i_dut.i_props.assertFails);
      if (errors == 0 && i_dut.i_props.assertFails == 0)
         $display("test passed");
      else
         $display("test failed");
      $finish;
   end

endmodule

// ==== verification/proc_properties.sv ====
//######################################
// Handshake and retire-trace checks
// Bound to the core top level
//######################################
`timescale 1ns/1ps

module procProperties (
   input logic clk,
   input logic rst,
   input logic req,
   input logic ack,
   input logic err,
   input logic retireValid
);

   // Number of failed properties so far
   int assertFails = 0;

   // Ack only answers a pending request
   assert property (@(posedge clk) disable iff (rst)
      $rose(ack) |-> $past(req))
   else
   begin
      $error("ack rose while req was low");
      assertFails++;
   end

   // Error flag only valid alongside ack
   assert property (@(posedge clk) disable iff (rst)
      err |-> ack)
   else
   begin
      $error("err high without ack");
      assertFails++;
   end

   // Nothing retires once stopped
   assert property (@(posedge clk) disable iff (rst)
      !(retireValid && ack))
   else
   begin
      $error("retireValid and ack high together");
      assertFails++;
   end

   // Ack stays up while req is held
   assert property (@(posedge clk) disable iff (rst)
      (ack && req) |=> ack)
   else
   begin
      $error("ack dropped before req fell");
      assertFails++;
   end

endmodule
